// ==== tb/model_load_tests.txt ====
# W <word hex> | D <bytes before calibration> | G <0 no gaps, 1 random gaps>
# R <word index> <expected word hex> | X reset and start second pass
D 80
G 0
W 00112233445566778899aabbccddeeff
W 0f1e2d3c4b5a69788796a5b4c3d2e1f0
W 0123456789abcdeffedcba9876543210
W deadbeefcafef00d0badc0de8badf00d
W 102030405060708090a0b0c0d0e0f000
W 5a5a5a5aa5a5a5a5c3c3c3c33c3c3c3c
W 00000000000000000000000000000001
W 80000000000000000000000000000000
W 13579bdf2468ace013579bdf2468ace0
W fedcba98765432100123456789abcdef
W 0a0b0c0d0e0f10111213141516171819
W ffffffffffffffffffffffffffffffff
W 123456789abcdef0123456789abcdef0
W 7766554433221100ffeeddccbbaa9988
W a1b2c3d4e5f60718293a4b5c6d7e8f90
W 3c5a7e9f0b1d2f4365879ba9cbedf012
R 0 00112233445566778899aabbccddeeff
R 3 deadbeefcafef00d0badc0de8badf00d
R 5 5a5a5a5aa5a5a5a5c3c3c3c33c3c3c3c
R 7 80000000000000000000000000000000
R 10 0a0b0c0d0e0f10111213141516171819
R 13 7766554433221100ffeeddccbbaa9988
R 15 3c5a7e9f0b1d2f4365879ba9cbedf012
X
D 0
G 1
R 14 a1b2c3d4e5f60718293a4b5c6d7e8f90
R 1 0f1e2d3c4b5a69788796a5b4c3d2e1f0
R 6 00000000000000000000000000000001
R 11 ffffffffffffffffffffffffffffffff
R 2 0123456789abcdeffedcba9876543210
R 4 102030405060708090a0b0c0d0e0f000

// ==== model_load.f ====
+incdir+logic
logic/ml_pkg.sv
logic/sd_byte_packer.sv
logic/ml_word_fifo.sv
logic/ml_app_writer.sv
logic/model_mem.sv
logic/model_load_top.sv
tb/tb_clock_gen.sv
tb/tb_model_load.sv

// ==== run.sh ====
#!/bin/sh
# build and run the model loader testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_model_load \
	-f model_load.f -o sim_model_load > build.log 2>&1 \
	|| { cat build.log; echo "FAIL"; exit 1; }
./obj_dir/sim_model_load > sim.log 2>&1
cat sim.log
grep -qx "Test OK" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== tb/tb_model_load.sv ====
`include "ml_defs.svh"

module tb_model_load;

	timeunit 1ns;
	timeprecision 1ps;

	// words the chain holds with calibration low, 4 in the FIFO and 1 in the packer
	localparam int chain_bytes = 80;
	localparam int stall_cycles = 20;

	logic                clk;
	logic                reset;
	logic                restart;
	logic                byte_valid;
	ml_pkg::sd_byte_t    byte_data;
	logic                byte_ready;
	logic                init_calib_complete;
	logic                rd_en;
	ml_pkg::word_index_t rd_addr;
	ml_pkg::ddr_word_t   rd_data;
	logic                rd_valid;
	logic                init_model_complete;
	logic                led;

	// test file contents
	ml_pkg::ddr_word_t words_q[$];
	ml_pkg::ddr_word_t rd_exp_q[$];
	int                rd_idx_q[$];
	int                rd_pass_q[$];
	int                delay_cfg[2];
	int                gap_cfg[2];
	int                n_pass;
	int                mismatches;
	int                faults;
	integer            seed;
	longint            watchdog_ns;

	tb_clock_gen clk0 (
		.restart	(restart	),
		.clk		(clk		),
		.reset		(reset		)
	);

	model_load_top dut0 (
		.clk					(clk					),
		.reset					(reset					),
		.byte_valid				(byte_valid				),
		.byte_data				(byte_data				),
		.byte_ready				(byte_ready				),
		.init_calib_complete	(init_calib_complete	),
		.rd_en					(rd_en					),
		.rd_addr				(rd_addr				),
		.rd_data				(rd_data				),
		.rd_valid				(rd_valid				),
		.init_model_complete	(init_model_complete	),
		.led					(led					)
	);

	task automatic check_value(input string name, input logic [127:0] exp,
			input logic [127:0] act);
		assert (act === exp) else begin
			mismatches++;
			$display("Mismatch at %0d ns: %s expected %0h, got %0h", $time, name, exp, act);
		end
	endtask

	task automatic check_true(input bit cond, input string what);
		assert (cond) else begin
			faults++;
			$display("Error at %0d ns: %s", $time, what);
		end
	endtask

	// one letter per line, then its fields; # lines are comments
	task automatic read_tests();
		int                fd;
		int                n;
		int                c;
		int                val;
		logic [7:0]        kind;
		ml_pkg::ddr_word_t word;
		fd = $fopen("tb/model_load_tests.txt", "r");
		check_true(fd != 0, "cannot open tb/model_load_tests.txt");
		if (fd == 0) begin
			return;
		end
		n_pass = 1;
		forever begin
			n = $fscanf(fd, " %c", kind);
			if (n != 1) begin
				break;
			end
			case (kind)
				"#": begin
					c = 0;
					while (c != "\n" && c != -1) begin
						c = $fgetc(fd);
					end
				end
				"W": begin
					n = $fscanf(fd, "%h", word);
					words_q.push_back(word);
				end
				"D": begin
					n = $fscanf(fd, "%d", val);
					delay_cfg[n_pass - 1] = val;
				end
				"G": begin
					n = $fscanf(fd, "%d", val);
					gap_cfg[n_pass - 1] = val;
				end
				"R": begin
					n = $fscanf(fd, "%d %h", val, word);
					rd_idx_q.push_back(val);
					rd_exp_q.push_back(word);
					rd_pass_q.push_back(n_pass - 1);
				end
				"X": begin
					check_true(n_pass < 2, "test file asks for more than two passes");
					n_pass = 2;
				end
				default: check_true(1'b0, "unknown line kind in test file");
			endcase
		end
		$fclose(fd);
	endtask

	// first pass uses the power-on reset, later ones request a new one
	task automatic start_pass(input int p);
		if (p != 0) begin
			@(negedge clk);
			restart = 1'b1;
			@(negedge clk);
			restart = 1'b0;
		end
		init_calib_complete = delay_cfg[p] == 0;
		while (reset) begin
			@(negedge clk);
		end
		check_value("byte_ready", 1, byte_ready);
		check_value("init_model_complete", 0, init_model_complete);
		check_value("led", 0, led);
		check_value("rd_valid", 0, rd_valid);
	endtask

	// words go out lowest byte first
	task automatic send_bytes(input int p);
		int                accepted;
		int                total;
		bit                gap;
		ml_pkg::ddr_word_t cur;
		accepted = 0;
		total = words_q.size() * `ML_WORD_BYTES;
		while (accepted < total) begin
			@(negedge clk);
			// calibration still low after D bytes, chain must hold
			if (!init_calib_complete && accepted >= delay_cfg[p]) begin
				byte_valid = 1'b0;
				repeat (stall_cycles) begin
					@(negedge clk);
					if (accepted == chain_bytes) begin
						check_value("byte_ready", 0, byte_ready);
					end
					check_value("init_model_complete", 0, init_model_complete);
				end
				init_calib_complete = 1'b1;
			end
			gap = gap_cfg[p] != 0 && ($random(seed) & 3) == 0;
			cur = words_q[accepted / `ML_WORD_BYTES];
			byte_valid = !gap;
			byte_data = cur[8 * (accepted % `ML_WORD_BYTES) +: 8];
			if (!init_calib_complete && accepted < chain_bytes) begin
				check_value("byte_ready", 1, byte_ready);
			end
			// ready only changes on clock edges, so this predicts the transfer
			if (byte_valid && byte_ready) begin
				accepted++;
			end
		end
		@(negedge clk);
		byte_valid = 1'b0;
	endtask

	task automatic read_back(input int p);
		int idx;
		for (int i = 0; i < rd_idx_q.size(); i++) begin
			if (rd_pass_q[i] == p) begin
				idx = rd_idx_q[i];
				check_true(words_q[idx] == rd_exp_q[i], "R line disagrees with its W word");
				@(negedge clk);
				check_value("rd_valid", 0, rd_valid);
				rd_en = 1'b1;
				rd_addr = ml_pkg::word_index_t'(idx);
				@(negedge clk);
				rd_en = 1'b0;
				check_value("rd_valid", 1, rd_valid);
				check_value("rd_data", rd_exp_q[i], rd_data);
				check_value("init_model_complete", 1, init_model_complete);
				check_value("led", 1, led);
			end
		end
		@(negedge clk);
		check_value("rd_valid", 0, rd_valid);
	endtask

	initial begin
		seed = 32'hf6d9;
		mismatches = 0;
		faults = 0;
		watchdog_ns = 0;
		restart = 1'b0;
		byte_valid = 1'b0;
		byte_data = '0;
		init_calib_complete = 1'b0;
		rd_en = 1'b0;
		rd_addr = '0;
		read_tests();
		check_true(words_q.size() == `ML_MODEL_WORDS, "test file does not hold one full model");
		// every byte may wait twice, plus stall, reset and read cycles, times 4
		watchdog_ns = 64'd80 * (n_pass * (words_q.size() * `ML_WORD_BYTES * 2
			+ stall_cycles + 40) + rd_idx_q.size() * 3);
		if (faults == 0) begin
			for (int p = 0; p < n_pass; p++) begin
				start_pass(p);
				send_bytes(p);
				while (!init_model_complete) begin
					@(negedge clk);
				end
				check_value("led", 1, led);
				read_back(p);
			end
		end
		$display("errors: %0d mismatches, %0d other", mismatches, faults);
		if (mismatches == 0 && faults == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

	// watchdog, armed once the test length is known
	initial begin
		wait (watchdog_ns != 0);
		#(watchdog_ns);
		faults++;
		$display("Timeout: load and read-back did not finish within %0d ns", watchdog_ns);
		$display("errors: %0d mismatches, %0d other", mismatches, faults);
		$display("Test FAILED");
		$finish;
	end

endmodule

// ==== tb/tb_clock_gen.sv ====
module tb_clock_gen (
	input  logic restart,
	output logic clk,
	output logic reset
);

	timeunit 1ns;
	timeprecision 1ps;

	// reset cycles still to go, starts loaded
	logic [3:0] hold = 4'd10;

	// 20 ns period
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// restart reloads the 10-cycle reset for a new pass
	always @(posedge clk) begin
		if (restart) begin
			hold <= 4'd10;
		end else if (hold != 4'd0) begin
			hold <= hold - 4'd1;
		end
	end

	assign reset = hold != 4'd0;

endmodule

// ==== logic/model_load_top.sv ====
module model_load_top (
	input  logic                clk,
	input  logic                reset,
	input  logic                byte_valid,
	input  ml_pkg::sd_byte_t    byte_data,
	output logic                byte_ready,
	input  logic                init_calib_complete,
	input  logic                rd_en,
	input  ml_pkg::word_index_t rd_addr,
	output ml_pkg::ddr_word_t   rd_data,
	output logic                rd_valid,
	output logic                init_model_complete,
	output logic                led
);

	// packer to FIFO
	logic                word_valid;
	ml_pkg::ddr_word_t   word_data;
	logic                word_ready;

	// FIFO to app writer
	logic                fifo_valid;
	ml_pkg::ddr_word_t   fifo_data;
	logic                fifo_pop;

	// app writer to memory
	logic                app_cmd_en;
	logic                app_wdf_wren;
	ml_pkg::word_index_t app_addr;
	ml_pkg::ddr_word_t   app_wdf_data;

	// model loaded indicator
	assign led = init_model_complete;

	// card bytes into 128-bit words
	sd_byte_packer packer0 (
		.clk			(clk			),
		.reset			(reset			),
		.byte_valid		(byte_valid		),
		.byte_data		(byte_data		),
		.byte_ready		(byte_ready		),
		.word_valid		(word_valid		),
		.word_data		(word_data		),
		.word_ready		(word_ready		)
	);

	// absorbs words while calibration is pending
	ml_word_fifo fifo0 (
		.clk			(clk			),
		.reset			(reset			),
		.word_valid		(word_valid		),
		.word_data		(word_data		),
		.word_ready		(word_ready		),
		.fifo_valid		(fifo_valid		),
		.fifo_data		(fifo_data		),
		.fifo_pop		(fifo_pop		)
	);

	ml_app_writer writer0 (
		.clk				(clk				),
		.reset				(reset				),
		.init_calib_complete(init_calib_complete),
		.fifo_valid			(fifo_valid			),
		.fifo_data			(fifo_data			),
		.fifo_pop			(fifo_pop			),
		.app_cmd_en			(app_cmd_en			),
		.app_wdf_wren		(app_wdf_wren		),
		.app_addr			(app_addr			),
		.app_wdf_data		(app_wdf_data		),
		.init_model_complete(init_model_complete)
	);

	// memory with read-back port
	model_mem mem0 (
		.clk			(clk			),
		.app_cmd_en		(app_cmd_en		),
		.app_wdf_wren	(app_wdf_wren	),
		.app_addr		(app_addr		),
		.app_wdf_data	(app_wdf_data	),
		.rd_en			(rd_en			),
		.rd_addr		(rd_addr		),
		.rd_data		(rd_data		),
		.rd_valid		(rd_valid		),
		.reset			(reset			)
	);

endmodule

// ==== logic/model_mem.sv ====
`include "ml_defs.svh"

module model_mem (
	input  logic                clk,
	input  logic                app_cmd_en,
	input  logic                app_wdf_wren,
	input  ml_pkg::word_index_t app_addr,
	input  ml_pkg::ddr_word_t   app_wdf_data,
	input  logic                rd_en,
	input  ml_pkg::word_index_t rd_addr,
	output ml_pkg::ddr_word_t   rd_data,
	output logic                rd_valid,
	input  logic                reset
);

	// stands in for the external ddr behind the app port
	ml_pkg::ddr_word_t mem [`ML_MODEL_WORDS];
	logic              wr_en;

	// a write needs both the command and its data
	assign wr_en = app_cmd_en && app_wdf_wren;

	// word stored on the write edge
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[app_addr] <= app_wdf_data;
		end
	end

	// registered read, data one cycle after rd_en
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_data <= mem[rd_addr];
		end
	end

	// read strobe follows rd_en by one cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= rd_en;
		end
	end

endmodule

// ==== logic/ml_app_writer.sv ====
`include "ml_defs.svh"

module ml_app_writer (
	input  logic                clk,
	input  logic                reset,
	input  logic                init_calib_complete,
	input  logic                fifo_valid,
	input  ml_pkg::ddr_word_t   fifo_data,
	output logic                fifo_pop,
	output logic                app_cmd_en,
	output logic                app_wdf_wren,
	output ml_pkg::word_index_t app_addr,
	output ml_pkg::ddr_word_t   app_wdf_data,
	output logic                init_model_complete
);

	ml_pkg::writer_state_t state;
	ml_pkg::word_index_t   addr_q;
	logic                  fire;
	logic                  last_word;

	// one write per cycle while a word is present and memory is calibrated
	assign fire = (state == ml_pkg::st_write) && init_calib_complete && fifo_valid;
	assign last_word = addr_q == ml_pkg::word_index_t'(`ML_MODEL_WORDS - 1);

	// command and data enables go together, memory never back-pressures
	assign fifo_pop = fire;
	assign app_cmd_en = fire;
	assign app_wdf_wren = fire;
	assign app_addr = addr_q;
	assign app_wdf_data = fifo_data;

	// done flag straight from state, drives the led too
	assign init_model_complete = state == ml_pkg::st_done;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ml_pkg::st_wait_calib;
			addr_q <= '0;
		end else begin
			if (fire) begin
				addr_q <= addr_q + 1'b1;
			end
			case (state)
				ml_pkg::st_wait_calib: begin
					if (init_calib_complete) begin
						state <= ml_pkg::st_write;
					end
				end
				ml_pkg::st_write: begin
					// whole image written
					if (fire && last_word) begin
						state <= ml_pkg::st_done;
					end else if (!init_calib_complete) begin
						state <= ml_pkg::st_wait_calib;
					end
				end
				// sticky until reset
				ml_pkg::st_done: state <= ml_pkg::st_done;
				default: state <= ml_pkg::st_wait_calib;
			endcase
		end
	end

	// writes only into a calibrated memory and never past the image
	assert property (@(posedge clk) disable iff (reset)
		app_cmd_en |-> init_calib_complete && !init_model_complete);

endmodule

// ==== logic/ml_word_fifo.sv ====
`include "ml_defs.svh"

module ml_word_fifo #(
	parameter int depth = `ML_FIFO_DEPTH
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              word_valid,
	input  ml_pkg::ddr_word_t word_data,
	output logic              word_ready,
	output logic              fifo_valid,
	output ml_pkg::ddr_word_t fifo_data,
	input  logic              fifo_pop
);

	localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
	localparam int cnt_w = $clog2(depth + 1);

	ml_pkg::ddr_word_t mem [depth];
	logic [ptr_w-1:0]  wr_ptr;
	logic [ptr_w-1:0]  rd_ptr;
	logic [cnt_w-1:0]  count;
	logic              push;

	// pointer step with wrap, depth need not be a power of two
	function automatic logic [ptr_w-1:0] ptr_next(input logic [ptr_w-1:0] ptr);
		ptr_next = (ptr == ptr_w'(depth - 1)) ? '0 : ptr + 1'b1;
	endfunction

	// full and empty from occupancy
	assign word_ready = count != cnt_w'(depth);
	assign fifo_valid = count != '0;
	assign push = word_valid && word_ready;

	// head word, shown as soon as count is nonzero
	assign fifo_data = mem[rd_ptr];

	// storage
	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= word_data;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= ptr_next(wr_ptr);
			end
			if (fifo_pop) begin
				rd_ptr <= ptr_next(rd_ptr);
			end
			// simultaneous push and pop leaves count as is
			case ({push, fifo_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// refused push is held by the producer, never dropped
	assert property (@(posedge clk) disable iff (reset)
		word_valid && !word_ready |=> word_valid);

	// consumer only pops a present word
	assert property (@(posedge clk) disable iff (reset)
		fifo_pop |-> fifo_valid);

endmodule

// ==== logic/sd_byte_packer.sv ====
`include "ml_defs.svh"

module sd_byte_packer (
	input  logic              clk,
	input  logic              reset,
	input  logic              byte_valid,
	input  ml_pkg::sd_byte_t  byte_data,
	output logic              byte_ready,
	output logic              word_valid,
	output ml_pkg::ddr_word_t word_data,
	input  logic              word_ready
);

	localparam int lane_w = $clog2(`ML_WORD_BYTES);
	localparam logic [lane_w-1:0] last_lane = lane_w'(`ML_WORD_BYTES - 1);

	logic [lane_w-1:0] lane_q;
	logic              byte_take;
	logic              word_take;

	// finished word leaves this cycle
	assign word_take = word_valid && word_ready;

	// stall bytes only while a full word is stuck
	// ready again in the cycle the FIFO takes it
	assign byte_ready = !word_valid || word_ready;
	assign byte_take = byte_valid && byte_ready;

	// new byte enters at the top and moves down one lane per byte
	// after 16 bytes the first one sits in bits 7:0
	always_ff @(posedge clk) begin
		if (byte_take) begin
			word_data <= {byte_data, word_data[8*`ML_WORD_BYTES-1:8]};
		end
	end

	// lane counter and word handshake
	always_ff @(posedge clk) begin
		if (reset) begin
			lane_q <= '0;
			word_valid <= 1'b0;
		end else begin
			if (byte_take) begin
				lane_q <= (lane_q == last_lane) ? '0 : lane_q + 1'b1;
			end
			// last lane filled, offer the word next cycle
			if (byte_take && lane_q == last_lane) begin
				word_valid <= 1'b1;
			end else if (word_take) begin
				word_valid <= 1'b0;
			end
		end
	end

	// no byte lands in a word that is still waiting on a full FIFO
	assert property (@(posedge clk) disable iff (reset)
		word_valid && !word_ready |=> word_valid && $stable(word_data));

endmodule

// ==== logic/ml_pkg.sv ====
`include "ml_defs.svh"

package ml_pkg;

	// one byte as read from the card
	typedef logic [7:0] sd_byte_t;

	// app data word, width of the ddr data path
	typedef logic [8*`ML_WORD_BYTES-1:0] ddr_word_t;

	// word address inside the model image
	typedef logic [$clog2(`ML_MODEL_WORDS)-1:0] word_index_t;

	// app writer FSM
	typedef enum logic [1:0] {
		st_wait_calib,
		st_write,
		st_done
	} writer_state_t;

endpackage

// ==== logic/ml_defs.svh ====
`ifndef ML_DEFS_SVH
`define ML_DEFS_SVH

// model image size in memory words
// one word per app write, addresses 0 .. N-1
`define ML_MODEL_WORDS 16

// default word FIFO depth between packer and writer
// with the packer's held word this sets the stall point
`define ML_FIFO_DEPTH 4

// card bytes packed into one memory word
// 16 bytes = 128-bit app data path
`define ML_WORD_BYTES 16

`endif
